// ==== design/cpu_control.sv ====
// instruction sequencer; pc starts at mem_base and only changes in the execute state
module cpu_control (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::word_t instr,
    input  logic           fetch_done,
    input  logic           operands_equal,
    input  logic           load_done,
    input  logic           store_done,
    output cpu_pkg::word_t pc,
    output logic           fetch_start,
    output logic           decode_en,
    output logic           execute_en,
    output logic           wb_en,
    output logic           load_start,
    output logic           store_start,
    output logic           io_stall
);

    cpu_pkg::ctrl_state_t state, state_nxt;
    cpu_pkg::opcode_t     op;
    logic [4:0]           imm;

    assign op  = cpu_pkg::instr_op(instr);
    assign imm = cpu_pkg::instr_imm(instr);

    always_comb begin
        state_nxt = state;
        case (state)
            cpu_pkg::ctrl_idle:   state_nxt = cpu_pkg::ctrl_fetch;
            cpu_pkg::ctrl_fetch:  if (fetch_done) state_nxt = cpu_pkg::ctrl_decode;
            cpu_pkg::ctrl_decode: state_nxt = cpu_pkg::ctrl_execute;
            cpu_pkg::ctrl_execute: begin
                case (op)
                    cpu_pkg::op_load:                  state_nxt = cpu_pkg::ctrl_load;
                    cpu_pkg::op_store:                 state_nxt = cpu_pkg::ctrl_store;
                    cpu_pkg::op_beq, cpu_pkg::op_jump: state_nxt = cpu_pkg::ctrl_fetch;
                    default:                           state_nxt = cpu_pkg::ctrl_write_back;
                endcase
            end
            cpu_pkg::ctrl_load:       if (load_done) state_nxt = cpu_pkg::ctrl_fetch;
            cpu_pkg::ctrl_store:      if (store_done) state_nxt = cpu_pkg::ctrl_fetch;
            cpu_pkg::ctrl_write_back: state_nxt = cpu_pkg::ctrl_fetch;
            default:                  state_nxt = cpu_pkg::ctrl_idle;
        endcase
    end

    // stage pulses are high in the first cycle of their state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= cpu_pkg::ctrl_idle;
            fetch_start <= 1'b0;
            decode_en   <= 1'b0;
            execute_en  <= 1'b0;
            wb_en       <= 1'b0;
            load_start  <= 1'b0;
            store_start <= 1'b0;
            io_stall    <= 1'b1;
        end else begin
            state       <= state_nxt;
            fetch_start <= state_nxt == cpu_pkg::ctrl_fetch && state != cpu_pkg::ctrl_fetch;
            decode_en   <= state_nxt == cpu_pkg::ctrl_decode;
            execute_en  <= state_nxt == cpu_pkg::ctrl_execute;
            wb_en       <= state_nxt == cpu_pkg::ctrl_write_back;
            load_start  <= state_nxt == cpu_pkg::ctrl_load && state != cpu_pkg::ctrl_load;
            store_start <= state_nxt == cpu_pkg::ctrl_store && state != cpu_pkg::ctrl_store;
            // retire strobe, skipped on the very first fetch
            io_stall    <= !(state_nxt == cpu_pkg::ctrl_fetch && state != cpu_pkg::ctrl_fetch
                             && state != cpu_pkg::ctrl_idle);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= cpu_pkg::word_t'(cpu_pkg::mem_base);
        end else if (state == cpu_pkg::ctrl_execute) begin
            if (op == cpu_pkg::op_beq && operands_equal)
                pc <= pc + 16'd2 + {{10{imm[4]}}, imm, 1'b0};
            else if (op == cpu_pkg::op_jump)
                pc <= {3'b000, cpu_pkg::instr_target(instr)};
            else
                pc <= pc + 16'd2;
        end
    end

endmodule

// ==== design/cpu_pkg.sv ====
// shared types for the 16-bit core; data addresses assume 16-bit word aligned accesses at mem_base
package cpu_pkg;

    // ########################################################################
    // widths and memory map
    // ########################################################################
    typedef logic [15:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  page_tag_t;
    typedef logic [6:0]  page_off_t;

    localparam addr_t mem_base   = 32'h0000_1000;
    localparam int    page_words = 128;

    // ########################################################################
    // opcodes and state machines
    // ########################################################################
    typedef enum logic [2:0] {
        op_arith  = 3'b000,
        op_cmpmul = 3'b001,
        op_load   = 3'b010,
        op_store  = 3'b011,
        op_beq    = 3'b100,
        op_jump   = 3'b101
    } opcode_t;

    typedef enum logic [2:0] {
        ctrl_idle, ctrl_fetch, ctrl_decode, ctrl_execute, ctrl_load, ctrl_store, ctrl_write_back
    } ctrl_state_t;

    typedef enum logic [2:0] {
        f_idle, f_hit, f_hit_wait, f_refill_addr, f_refill_data, f_done
    } fetch_state_t;

    typedef enum logic [2:0] {
        m_idle, m_rd_addr, m_rd_data, m_wr_req, m_wr_resp
    } mem_state_t;

    // ########################################################################
    // bus channels and internal requests
    // ########################################################################
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
    } ar_req_t;

    typedef struct packed {
        word_t rdata;
        logic  rlast;
        logic  rvalid;
    } r_resp_t;

    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        word_t wdata;
        logic  wlast;
        logic  wvalid;
    } aw_w_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } wr_ack_t;

    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        reg_idx_t dest;
    } mem_req_t;

    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } reg_wr_t;

    // instruction fields
    function automatic opcode_t instr_op(word_t i);
        return opcode_t'(i[15:13]);
    endfunction

    function automatic reg_idx_t instr_rs(word_t i);
        return i[12:9];
    endfunction

    function automatic reg_idx_t instr_rt(word_t i);
        return i[8:5];
    endfunction

    function automatic reg_idx_t instr_rd(word_t i);
        return i[4:1];
    endfunction

    function automatic logic instr_func(word_t i);
        return i[0];
    endfunction

    // signed 5-bit immediate
    function automatic logic [4:0] instr_imm(word_t i);
        return i[4:0];
    endfunction

    function automatic logic [12:0] instr_target(word_t i);
        return i[12:0];
    endfunction

endpackage

// ==== design/cpu_top.sv ====
// top level of the core; one instruction read port, one data read port and one write port
module cpu_top (
    input  logic                clk,
    input  logic                rst_n,
    output logic                io_stall,
    output cpu_pkg::ar_req_t    inst_ar,
    input  cpu_pkg::r_resp_t    inst_r,
    output logic                inst_rready,
    output cpu_pkg::ar_req_t    data_ar,
    input  cpu_pkg::r_resp_t    data_r,
    output logic                data_rready,
    output cpu_pkg::aw_w_req_t  data_wr,
    input  cpu_pkg::wr_ack_t    data_wr_ack,
    output logic                bready
);

    cpu_pkg::word_t    instr;
    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    rt_val;
    cpu_pkg::word_t    load_data;
    cpu_pkg::reg_idx_t rs_idx;
    cpu_pkg::reg_idx_t rt_idx;
    cpu_pkg::mem_req_t mem_req;
    cpu_pkg::reg_wr_t  wr;
    logic fetch_start, fetch_done;
    logic decode_en, execute_en, wb_en;
    logic load_start, store_start, load_done, store_done;
    logic operands_equal;

    cpu_control u_control (
        .clk, .rst_n, .instr, .fetch_done, .operands_equal, .load_done, .store_done,
        .pc, .fetch_start, .decode_en, .execute_en, .wb_en, .load_start, .store_start,
        .io_stall
    );

    inst_cache u_inst_cache (
        .clk, .rst_n, .fetch_start, .pc, .instr, .fetch_done, .inst_ar, .inst_r, .inst_rready
    );

    reg_file u_reg_file (
        .clk, .rst_n, .rs_idx, .rt_idx, .rs_val, .rt_val, .wr
    );

    execute_unit u_execute (
        .clk, .rst_n, .instr, .decode_en, .execute_en, .wb_en, .rs_val, .rt_val,
        .rs_idx, .rt_idx, .operands_equal, .mem_req, .load_done, .load_data, .wr
    );

    data_port u_data_port (
        .clk, .rst_n, .load_start, .store_start, .mem_req, .load_done, .store_done,
        .load_data, .data_ar, .data_r, .data_rready, .data_wr, .data_wr_ack, .bready
    );

endmodule

// ==== design/data_port.sv ====
// single-beat data master; the first rvalid also acknowledges the read address
module data_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_start,
    input  logic                store_start,
    input  cpu_pkg::mem_req_t   mem_req,
    output logic                load_done,
    output logic                store_done,
    output cpu_pkg::word_t      load_data,
    output cpu_pkg::ar_req_t    data_ar,
    input  cpu_pkg::r_resp_t    data_r,
    output logic                data_rready,
    output cpu_pkg::aw_w_req_t  data_wr,
    input  cpu_pkg::wr_ack_t    data_wr_ack,
    output logic                bready
);

    cpu_pkg::mem_state_t state;
    logic                aw_ok, w_ok;

    assign data_rready = state == cpu_pkg::m_rd_data;
    assign bready      = state == cpu_pkg::m_wr_resp;
    // each write channel is done once its valid has dropped or is accepted now
    assign aw_ok = !data_wr.awvalid || data_wr_ack.awready;
    assign w_ok  = !data_wr.wvalid || data_wr_ack.wready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= cpu_pkg::m_idle;
            data_ar    <= '0;
            data_wr    <= '0;
            load_done  <= 1'b0;
            store_done <= 1'b0;
        end else begin
            load_done  <= 1'b0;
            store_done <= 1'b0;
            case (state)
                cpu_pkg::m_idle: begin
                    if (load_start) begin
                        state           <= cpu_pkg::m_rd_addr;
                        data_ar.arvalid <= 1'b1;
                        data_ar.araddr  <= mem_req.addr;
                    end else if (store_start) begin
                        state           <= cpu_pkg::m_wr_req;
                        data_wr.awaddr  <= mem_req.addr;
                        data_wr.wdata   <= mem_req.wdata;
                        data_wr.awvalid <= 1'b1;
                        data_wr.wvalid  <= 1'b1;
                        data_wr.wlast   <= 1'b1;
                    end
                end
                cpu_pkg::m_rd_addr: state <= cpu_pkg::m_rd_data;
                cpu_pkg::m_rd_data: begin
                    if (data_r.rvalid) begin
                        data_ar.arvalid <= 1'b0;
                        if (data_r.rlast) begin
                            state     <= cpu_pkg::m_idle;
                            load_done <= 1'b1;
                        end
                    end
                end
                cpu_pkg::m_wr_req: begin
                    if (data_wr_ack.awready)
                        data_wr.awvalid <= 1'b0;
                    if (data_wr_ack.wready) begin
                        data_wr.wvalid <= 1'b0;
                        data_wr.wlast  <= 1'b0;
                    end
                    if (aw_ok && w_ok)
                        state <= cpu_pkg::m_wr_resp;
                end
                cpu_pkg::m_wr_resp: begin
                    if (data_wr_ack.bvalid) begin
                        state      <= cpu_pkg::m_idle;
                        store_done <= 1'b1;
                    end
                end
                default: state <= cpu_pkg::m_idle;
            endcase
        end
    end

    // read data register, valid alongside load_done
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::m_rd_data && data_r.rvalid)
            load_data <= data_r.rdata;
    end

endmodule

// ==== design/execute_unit.sv ====
// operand latch, ALU and memory address; slt and mult treat operands as signed
module execute_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    instr,
    input  logic              decode_en,
    input  logic              execute_en,
    input  logic              wb_en,
    input  cpu_pkg::word_t    rs_val,
    input  cpu_pkg::word_t    rt_val,
    output cpu_pkg::reg_idx_t rs_idx,
    output cpu_pkg::reg_idx_t rt_idx,
    output logic              operands_equal,
    output cpu_pkg::mem_req_t mem_req,
    input  logic              load_done,
    input  cpu_pkg::word_t    load_data,
    output cpu_pkg::reg_wr_t  wr
);

    cpu_pkg::word_t rs_q, rt_q, alu_q, alu_res, eff_idx;
    logic [4:0]     imm;

    assign rs_idx         = cpu_pkg::instr_rs(instr);
    assign rt_idx         = cpu_pkg::instr_rt(instr);
    assign imm            = cpu_pkg::instr_imm(instr);
    assign operands_equal = rs_q == rt_q;
    assign eff_idx        = rs_q + {{11{imm[4]}}, imm};

    always_comb begin
        case (cpu_pkg::instr_op(instr))
            cpu_pkg::op_arith:  alu_res = cpu_pkg::instr_func(instr) ? rs_q - rt_q : rs_q + rt_q;
            cpu_pkg::op_cmpmul: alu_res = cpu_pkg::instr_func(instr) ? rs_q * rt_q :
                                          {15'd0, $signed(rs_q) < $signed(rt_q)};
            default:            alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_q    <= '0;
            rt_q    <= '0;
            alu_q   <= '0;
            mem_req <= '0;
        end else if (decode_en) begin
            rs_q <= rs_val;
            rt_q <= rt_val;
        end else if (execute_en) begin
            alu_q         <= alu_res;
            // word index to byte address
            mem_req.addr  <= cpu_pkg::mem_base + {15'd0, eff_idx, 1'b0};
            mem_req.wdata <= rt_q;
            mem_req.dest  <= rt_idx;
        end
    end

    // load data has priority, the two never overlap
    assign wr.we   = wb_en || load_done;
    assign wr.idx  = load_done ? mem_req.dest : cpu_pkg::instr_rd(instr);
    assign wr.data = load_done ? load_data : alu_q;

endmodule

// ==== design/inst_cache.sv ====
// one-page instruction cache; a miss refills all 128 words, so the slave must send a full burst
module inst_cache (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_start,
    input  cpu_pkg::word_t    pc,
    output cpu_pkg::word_t    instr,
    output logic              fetch_done,
    output cpu_pkg::ar_req_t  inst_ar,
    input  cpu_pkg::r_resp_t  inst_r,
    output logic              inst_rready
);

    cpu_pkg::fetch_state_t state;
    cpu_pkg::page_tag_t    tag, pc_tag;
    cpu_pkg::page_off_t    pc_off, beat_cnt;
    logic                  page_valid;
    logic                  hit;
    cpu_pkg::word_t        cache_mem [cpu_pkg::page_words];

    assign pc_tag      = pc[11:8];
    assign pc_off      = pc[7:1];
    assign hit         = page_valid && tag == pc_tag;
    assign inst_rready = state == cpu_pkg::f_refill_data;

    // ########################################################################
    // fetch FSM and read address channel
    // ########################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= cpu_pkg::f_idle;
            tag        <= '0;
            page_valid <= 1'b0;
            beat_cnt   <= '0;
            fetch_done <= 1'b0;
            inst_ar    <= '0;
        end else begin
            fetch_done <= state == cpu_pkg::f_done;
            case (state)
                cpu_pkg::f_idle: begin
                    if (fetch_start && hit) begin
                        state <= cpu_pkg::f_hit;
                    end else if (fetch_start) begin
                        state           <= cpu_pkg::f_refill_addr;
                        beat_cnt        <= '0;
                        inst_ar.arvalid <= 1'b1;
                        // page base in bytes
                        inst_ar.araddr  <= cpu_pkg::mem_base + {20'd0, pc_tag, 8'd0};
                    end
                end
                cpu_pkg::f_hit:         state <= cpu_pkg::f_hit_wait;
                cpu_pkg::f_hit_wait:    state <= cpu_pkg::f_done;
                cpu_pkg::f_refill_addr: state <= cpu_pkg::f_refill_data;
                cpu_pkg::f_refill_data: begin
                    if (inst_r.rvalid) begin
                        // first beat also accepts the address
                        inst_ar.arvalid <= 1'b0;
                        beat_cnt        <= beat_cnt + 7'd1;
                        if (inst_r.rlast) begin
                            state      <= cpu_pkg::f_done;
                            tag        <= pc_tag;
                            page_valid <= 1'b1;
                        end
                    end
                end
                cpu_pkg::f_done: state <= cpu_pkg::f_idle;
                default:         state <= cpu_pkg::f_idle;
            endcase
        end
    end

    // ########################################################################
    // page array and instruction register
    // ########################################################################
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::f_refill_data && inst_r.rvalid) begin
            cache_mem[beat_cnt] <= inst_r.rdata;
            // requested word goes straight out, no second lookup
            if (beat_cnt == pc_off)
                instr <= inst_r.rdata;
        end else if (state == cpu_pkg::f_hit) begin
            instr <= cache_mem[pc_off];
        end
    end

endmodule

// ==== design/reg_file.sv ====
// sixteen general registers; reads are combinational, a write shows on the next cycle
module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    rt_val,
    input  cpu_pkg::reg_wr_t  wr
);

    cpu_pkg::word_t regs [16];

    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (wr.we) begin
            regs[wr.idx] <= wr.data;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu -f sources.f -o sim_cpu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_cpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== sources.f ====
design/cpu_pkg.sv
design/reg_file.sv
design/execute_unit.sv
design/data_port.sv
design/inst_cache.sv
design/cpu_control.sv
design/cpu_top.sv
verification/dram_model.sv
verification/tb_cpu.sv

// ==== verification/dram_model.sv ====
// memory slave for the testbench; arvalid alone starts a read, and covers byte addresses 0x1000-0x1fff
module dram_model #(
    parameter int burst_len = 1,
    parameter bit has_write = 1'b0,
    parameter int seed_init = 81035
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_en,
    input  cpu_pkg::ar_req_t    ar,
    output cpu_pkg::r_resp_t    r,
    input  logic                rready,
    input  cpu_pkg::aw_w_req_t  wr,
    output cpu_pkg::wr_ack_t    wr_ack,
    input  logic                bready
);
    timeunit 1ns;
    timeprecision 1ps;

    cpu_pkg::word_t mem [2048];
    cpu_pkg::addr_t raddr, waddr;
    cpu_pkg::word_t wdata_q;
    logic           busy, took, got_aw, got_w;
    int             beat;
    int             seed = seed_init;

    // ready or valid this cycle, random only while stalls are on
    function logic pick_ready();
        return !stall_en || ($random(seed) & 3) != 0;
    endfunction

    // handshakes are taken on the rising edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            took    <= 1'b0;
            beat    <= 0;
            raddr   <= '0;
            got_aw  <= 1'b0;
            got_w   <= 1'b0;
            waddr   <= '0;
            wdata_q <= '0;
        end else begin
            took <= r.rvalid && rready;
            if (!busy && ar.arvalid) begin
                busy  <= 1'b1;
                raddr <= ar.araddr;
                beat  <= 0;
            end else if (busy && r.rvalid && rready) begin
                raddr <= raddr + 2;
                beat  <= beat + 1;
                if (beat == burst_len - 1)
                    busy <= 1'b0;
            end
            if (wr.awvalid && wr_ack.awready) begin
                got_aw <= 1'b1;
                waddr  <= wr.awaddr;
            end
            if (wr.wvalid && wr_ack.wready) begin
                got_w   <= 1'b1;
                wdata_q <= wr.wdata;
            end
            if (wr_ack.bvalid && bready) begin
                got_aw             <= 1'b0;
                got_w              <= 1'b0;
                mem[waddr[11:1]]   <= wdata_q;
            end
        end
    end

    // outputs change on the falling edge
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r      <= '0;
            wr_ack <= '0;
        end else begin
            if (r.rvalid && !took) begin
                // beat not taken yet, hold it
                r <= r;
            end else if (busy && pick_ready()) begin
                r.rvalid <= 1'b1;
                r.rdata  <= mem[raddr[11:1]];
                r.rlast  <= beat == burst_len - 1;
            end else begin
                r <= '0;
            end
            if (has_write) begin
                wr_ack.awready <= !got_aw && pick_ready();
                wr_ack.wready  <= !got_w && pick_ready();
                wr_ack.bvalid  <= got_aw && got_w && (wr_ack.bvalid || pick_ready());
            end
        end
    end

endmodule

// ==== verification/tb_cpu.sv ====
// programs are written straight into the memory models; unused words hold a jump to themselves
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 4;
    localparam int seed_init  = 81035;
    // retired instructions of all tests scale the watchdog
    localparam int total_retired = 1 + 10 + 2 + 8 + 3 + 10;

    logic clk, rst_n, stall_en;
    logic io_stall, inst_rready, data_rready, bready;
    logic ar_prev;
    cpu_pkg::ar_req_t   inst_ar, data_ar;
    cpu_pkg::r_resp_t   inst_r, data_r;
    cpu_pkg::aw_w_req_t data_wr;
    cpu_pkg::wr_ack_t   data_wr_ack;
    cpu_pkg::addr_t     burst_addrs[$], wr_addrs[$], exp_addrs[$];
    cpu_pkg::word_t     wr_data[$], exp_data[$];
    int errors = 0, mon_errors = 0, pulses = 0, tests = 0;
    int pulse_base, burst_base, write_base, err_before;

    cpu_top UUT (
        .clk, .rst_n, .io_stall, .inst_ar, .inst_r, .inst_rready, .data_ar, .data_r,
        .data_rready, .data_wr, .data_wr_ack, .bready
    );

    dram_model #(.burst_len(cpu_pkg::page_words), .has_write(1'b0), .seed_init(seed_init)) imem (
        .clk, .rst_n, .stall_en, .ar(inst_ar), .r(inst_r), .rready(inst_rready),
        .wr('0), .wr_ack(), .bready(1'b0)
    );

    dram_model #(.burst_len(1), .has_write(1'b1), .seed_init(seed_init)) dmem (
        .clk, .rst_n, .stall_en, .ar(data_ar), .r(data_r), .rready(data_rready),
        .wr(data_wr), .wr_ack(data_wr_ack), .bready
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(total_retired * 400 * clk_period);
        $display("timeout: the program did not retire its instructions in time");
        $display("sim failed");
        $finish;
    end

    // ########################################################################
    // bus monitor
    // ########################################################################
    always @(posedge clk) begin
        if (rst_n && !io_stall)
            pulses <= pulses + 1;
        ar_prev <= inst_ar.arvalid;
        if (inst_ar.arvalid && !ar_prev)
            burst_addrs.push_back(inst_ar.araddr);
        if (data_wr.awvalid && data_wr_ack.awready)
            wr_addrs.push_back(data_wr.awaddr);
        if (data_wr.wvalid && data_wr_ack.wready) begin
            wr_data.push_back(data_wr.wdata);
            assert (data_wr.wlast) else begin
                $display("CHECK FAILED wlast: got %h expected %h", data_wr.wlast, 1'b1);
                mon_errors <= mon_errors + 1;
            end
        end
    end

    // ########################################################################
    // helpers
    // ########################################################################
    function automatic cpu_pkg::word_t data_fill(int idx);
        return 16'(idx * 16'h9e37 ^ 16'h8421);
    endfunction

    function automatic cpu_pkg::word_t encode_reg(cpu_pkg::opcode_t op, int rs, int rt, int rd,
                                                  bit f);
        return {op, 4'(rs), 4'(rt), 4'(rd), f};
    endfunction

    function automatic cpu_pkg::word_t encode_imm(cpu_pkg::opcode_t op, int rs, int rt, int imm);
        return {op, 4'(rs), 4'(rt), 5'(imm)};
    endfunction

    function automatic cpu_pkg::word_t encode_jump(int target);
        return {cpu_pkg::op_jump, 13'(target)};
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_idle();
        check_value("io_stall", 32'(io_stall), 32'd1);
        check_value("inst_ar.arvalid", 32'(inst_ar.arvalid), 32'd0);
        check_value("inst_rready", 32'(inst_rready), 32'd0);
        check_value("data_ar.arvalid", 32'(data_ar.arvalid), 32'd0);
        check_value("data_rready", 32'(data_rready), 32'd0);
        check_value("data_wr.awvalid", 32'(data_wr.awvalid), 32'd0);
        check_value("data_wr.wvalid", 32'(data_wr.wvalid), 32'd0);
        check_value("bready", 32'(bready), 32'd0);
    endtask

    task automatic prepare(logic stall);
        for (int i = 0; i < 2048; i++) begin
            imem.mem[i] = encode_jump(32'h1000 + 2 * i);
            dmem.mem[i] = data_fill(i);
        end
        stall_en = stall;
        exp_addrs.delete();
        exp_data.delete();
        err_before = errors + mon_errors;
    endtask

    task automatic expect_write(int idx, cpu_pkg::word_t d);
        exp_addrs.push_back(32'h1000 + 2 * idx);
        exp_data.push_back(d);
    endtask

    task automatic run_program(int n);
        rst_n = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        pulse_base = pulses;
        burst_base = burst_addrs.size();
        write_base = wr_addrs.size();
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();
        while (pulses - pulse_base < n)
            @(negedge clk);
    endtask

    task automatic check_results(string name, int bursts);
        int n;
        n = wr_addrs.size() - write_base;
        check_value("burst count", 32'(burst_addrs.size() - burst_base), 32'(bursts));
        check_value("inst_ar.araddr", burst_addrs[burst_base], 32'h1000);
        check_value("write count", 32'(n), 32'(exp_addrs.size()));
        for (int i = 0; i < n && i < exp_addrs.size(); i++) begin
            check_value("data_wr.awaddr", wr_addrs[write_base + i], exp_addrs[i]);
            check_value("data_wr.wdata", 32'(wr_data[write_base + i]), 32'(exp_data[i]));
            check_value("dram word", 32'(dmem.mem[exp_addrs[i][11:1]]), 32'(exp_data[i]));
        end
        tests++;
        $display("test %0d %s: %s", tests, name,
                 errors + mon_errors == err_before ? "ok" : "errors");
    endtask

    task automatic arith_program();
        cpu_pkg::word_t a, b;
        a = data_fill(0);
        b = data_fill(1);
        imem.mem[0] = encode_imm(cpu_pkg::op_load, 0, 1, 0);
        imem.mem[1] = encode_imm(cpu_pkg::op_load, 0, 2, 1);
        imem.mem[2] = encode_reg(cpu_pkg::op_arith, 1, 2, 3, 1'b0);
        imem.mem[3] = encode_reg(cpu_pkg::op_arith, 1, 2, 4, 1'b1);
        imem.mem[4] = encode_reg(cpu_pkg::op_cmpmul, 1, 2, 5, 1'b0);
        imem.mem[5] = encode_reg(cpu_pkg::op_cmpmul, 1, 2, 6, 1'b1);
        for (int i = 0; i < 4; i++)
            imem.mem[6 + i] = encode_imm(cpu_pkg::op_store, 0, 3 + i, 8 + i);
        expect_write(8, a + b);
        expect_write(9, a - b);
        expect_write(10, ($signed(a) < $signed(b)) ? 16'd1 : 16'd0);
        expect_write(11, 16'(a * b));
    endtask

    // ########################################################################
    // test sequence
    // ########################################################################
    initial begin
        rst_n = 1'b0;
        stall_en = 1'b0;
        ar_prev = 1'b0;

        prepare(1'b0);
        run_program(1);
        check_results("reset", 1);

        prepare(1'b0);
        arith_program();
        run_program(10);
        check_results("arithmetic", 1);

        prepare(1'b0);
        imem.mem[0] = encode_imm(cpu_pkg::op_load, 0, 7, 3);
        imem.mem[1] = encode_imm(cpu_pkg::op_store, 0, 7, 12);
        expect_write(12, data_fill(3));
        run_program(2);
        check_results("load store", 1);

        // taken beq skips word 3, untaken beq falls through, jump skips word 8
        prepare(1'b0);
        imem.mem[0] = encode_imm(cpu_pkg::op_load, 0, 1, 0);
        imem.mem[1] = encode_imm(cpu_pkg::op_load, 0, 2, 0);
        imem.mem[2] = encode_imm(cpu_pkg::op_beq, 1, 2, 1);
        imem.mem[3] = encode_imm(cpu_pkg::op_store, 0, 1, 12);
        imem.mem[4] = encode_imm(cpu_pkg::op_load, 0, 3, 1);
        imem.mem[5] = encode_imm(cpu_pkg::op_beq, 1, 3, 1);
        imem.mem[6] = encode_imm(cpu_pkg::op_store, 0, 3, 13);
        imem.mem[7] = encode_jump(32'h1012);
        imem.mem[8] = encode_imm(cpu_pkg::op_store, 0, 1, 14);
        imem.mem[9] = encode_imm(cpu_pkg::op_store, 0, 2, 15);
        expect_write(13, data_fill(1));
        expect_write(15, data_fill(0));
        run_program(8);
        check_results("branch jump", 1);

        prepare(1'b0);
        imem.mem[0] = encode_imm(cpu_pkg::op_load, 0, 1, 2);
        imem.mem[1] = encode_jump(32'h1100);
        imem.mem[128] = encode_imm(cpu_pkg::op_store, 0, 1, 14);
        expect_write(14, data_fill(2));
        run_program(3);
        check_value("inst_ar.araddr", burst_addrs[burst_base + 1], 32'h1100);
        check_results("cache", 2);

        prepare(1'b1);
        arith_program();
        run_program(10);
        check_results("back-pressure", 1);

        $display("tests %0d, errors %0d", tests, errors + mon_errors);
        if (errors + mon_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
